/* clusterPkg.sv */
package clusterPkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 12;
    localparam int REG_COUNT  = 16;                // Set by the 4-bit register fields
    localparam int REG_IDX_W  = $clog2(REG_COUNT);

    // Instruction bits 31..29
    typedef enum logic [2:0] {
        Rtype = 3'd0,
        Itype = 3'd1,
        Mtype = 3'd2,
        Ctype = 3'd3,
        Ptype = 3'd4,
        Ftype = 3'd5
    } opClass;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_DIV  = 4'd3,                           // Reserved, decodes as ADD
        ALU_SLT  = 4'd4,
        ALU_SGT  = 4'd5,
        ALU_SEQ  = 4'd6,
        ALU_SNEZ = 4'd7,
        ALU_MIN  = 4'd8,
        ALU_ABS  = 4'd9,
        ALU_SLLI = 4'd10
    } aluOp;

    // C-type funct3 codes
    localparam logic [2:0] C_SYNC = 3'd6;
    localparam logic [2:0] C_EXIT = 3'd7;

    typedef enum logic {
        immI = 1'b0,
        immP = 1'b1
    } immSel;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            opClass          op;
            logic            predicate;
            logic [3:0]      rd;
            logic [3:0]      rs1;
            logic [3:0]      rs2;
            logic [1:0]      spare0;
            logic [3:0]      funct4;
            logic [9:0]      spare1;
        } rForm;
        struct packed {
            opClass          op;
            logic            predicate;
            logic [3:0]      rd;
            logic [3:0]      rs1;
            logic [5:0]      spare;
            logic [3:0]      funct4;
            logic [9:0]      imm10;
        } iForm;
        struct packed {
            opClass          op;
            logic            predicate;
            logic [3:0]      rd;
            logic [23:0]     imm24;
        } pForm;
    } instrWord;

    // Host address map
    localparam logic [ADDR_WIDTH-1:0] INSTR_ADDR  = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] REG_BASE    = 12'h100;
    localparam int                    LANE_SHIFT  = 6;   // 64 bytes per lane

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* laneCmdIf.sv */
`timescale 1ns/1ps

interface laneCmdIf;

    logic                                  valid;       // One-cycle pulse
    clusterPkg::aluOp                      aluOp;
    logic                                  useImm;
    logic                                  regWrite;
    logic                                  predicated;  // Gate on r15 bit 0
    logic [clusterPkg::REG_IDX_W-1:0]      rd;
    logic [clusterPkg::REG_IDX_W-1:0]      rs1;
    logic [clusterPkg::REG_IDX_W-1:0]      rs2;
    logic [clusterPkg::DATA_WIDTH-1:0]     imm;

    modport issue (
        output valid, aluOp, useImm, regWrite, predicated, rd, rs1, rs2, imm
    );

    modport lane (
        input valid, aluOp, useImm, regWrite, predicated, rd, rs1, rs2, imm
    );

endinterface

/* laneReadIf.sv */
`timescale 1ns/1ps

interface laneReadIf #(
    parameter int NUM_LANES = 4
);

    logic [clusterPkg::REG_IDX_W-1:0]  regIdx;            // Same index to every lane
    logic [clusterPkg::DATA_WIDTH-1:0] data [NUM_LANES];  // One word per lane

    modport collector (output regIdx, input data);

    modport lane (input regIdx, output data);

endinterface

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  clusterPkg::instrWord instr,
    output clusterPkg::aluOp     aluOp,
    output logic                 useImm,
    output logic                 immKind,
    output logic                 regWrite,
    output logic                 exit,
    output logic                 legal
);

    logic [3:0] funct4;
    logic [2:0] funct3;

    assign funct4 = instr.rForm.funct4;
    assign funct3 = instr.rForm.funct4[2:0];

    always_comb begin
        // Defaults describe an illegal word
        aluOp    = clusterPkg::ALU_ADD;
        useImm   = 1'b0;
        immKind  = clusterPkg::immI;
        regWrite = 1'b0;
        exit     = 1'b0;
        legal    = 1'b0;

        case (instr.rForm.op)
            clusterPkg::Rtype: begin
                case (funct4)
                    clusterPkg::ALU_SUB,
                    clusterPkg::ALU_MUL,
                    clusterPkg::ALU_SLT,
                    clusterPkg::ALU_SGT,
                    clusterPkg::ALU_SEQ,
                    clusterPkg::ALU_SNEZ,
                    clusterPkg::ALU_MIN,
                    clusterPkg::ALU_ABS: aluOp = clusterPkg::aluOp'(funct4);
                    default:             aluOp = clusterPkg::ALU_ADD;  // DIV lands here too
                endcase
                regWrite = 1'b1;
                legal    = 1'b1;
            end

            clusterPkg::Itype: begin
                case (funct4)
                    clusterPkg::ALU_MUL:  aluOp = clusterPkg::ALU_MUL;
                    clusterPkg::ALU_SLLI: aluOp = clusterPkg::ALU_SLLI;
                    default:              aluOp = clusterPkg::ALU_ADD;
                endcase
                useImm   = 1'b1;
                regWrite = 1'b1;
                legal    = 1'b1;
            end

            clusterPkg::Ptype: begin
                // ABS of a zero-extended immediate is the immediate itself
                aluOp    = clusterPkg::ALU_ABS;
                useImm   = 1'b1;
                immKind  = clusterPkg::immP;
                regWrite = 1'b1;
                legal    = 1'b1;
            end

            clusterPkg::Ctype: begin
                if (funct3 == clusterPkg::C_SYNC) begin
                    legal = 1'b1;                                   // Nothing to wait for
                end else if (funct3 == clusterPkg::C_EXIT) begin
                    exit  = 1'b1;
                    legal = 1'b1;
                end
            end

            default: begin
                // Memory and floating-point classes keep the defaults
            end
        endcase
    end

    always_comb begin
        assert final (legal || (!regWrite && !exit))
            else $error("controlUnit: side effect on an illegal word");
    end

endmodule

/* issueFrontend.sv */
`timescale 1ns/1ps

module issueFrontend (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [clusterPkg::ADDR_WIDTH-1:0]   awAddr,
    input  logic                                awValid,
    output logic                                awReady,
    input  logic [clusterPkg::DATA_WIDTH-1:0]   wData,
    input  logic                                wValid,
    output logic                                wReady,
    output logic [1:0]                          bResp,
    output logic                                bValid,
    input  logic                                bReady,
    laneCmdIf.issue                             cmd,
    output logic                                exited
);

    clusterPkg::instrWord                word;
    clusterPkg::aluOp                    decOp;
    logic                                decUseImm;
    logic                                decImmKind;
    logic                                decRegWrite;
    logic                                decExit;
    logic                                decLegal;
    logic                                accept;
    logic                                writeOk;
    logic [clusterPkg::DATA_WIDTH-1:0]   immValue;

    assign word = wData;

    controlUnit decoder (
        .instr    (word),
        .aluOp    (decOp),
        .useImm   (decUseImm),
        .immKind  (decImmKind),
        .regWrite (decRegWrite),
        .exit     (decExit),
        .legal    (decLegal)
    );

    // Address and data are taken together, one word in flight
    assign accept  = awValid && wValid && !bValid;
    assign awReady = accept;
    assign wReady  = accept;

    assign writeOk = (awAddr == clusterPkg::INSTR_ADDR) && !exited && decLegal;

    always_comb begin
        if (decImmKind == clusterPkg::immP) begin
            immValue = {{(clusterPkg::DATA_WIDTH-24){1'b0}}, word.pForm.imm24};
        end else begin
            immValue = {{(clusterPkg::DATA_WIDTH-10){word.iForm.imm10[9]}}, word.iForm.imm10};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bValid    <= 1'b0;
            cmd.valid <= 1'b0;
            exited    <= 1'b0;
        end else begin
            cmd.valid <= accept && writeOk;                 // Single pulse, lanes never stall
            if (accept) begin
                bValid <= 1'b1;
                exited <= exited || (writeOk && decExit);
            end else if (bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    // Response and command payload, held until the next accepted write
    always_ff @(posedge clk) begin
        if (accept) begin
            bResp          <= writeOk ? clusterPkg::RESP_OKAY : clusterPkg::RESP_SLVERR;
            cmd.aluOp      <= decOp;
            cmd.useImm     <= decUseImm;
            cmd.regWrite   <= decRegWrite;
            cmd.predicated <= word.rForm.predicate;
            cmd.rd         <= word.rForm.rd;
            cmd.rs1        <= word.rForm.rs1;
            cmd.rs2        <= word.rForm.rs2;
            cmd.imm        <= immValue;
        end
    end

    bHold: assert property (@(posedge clk) disable iff (rst)
        bValid && !bReady |=> bValid && $stable(bResp))
        else $error("issueFrontend: write response changed before bReady");

endmodule

/* simdLane.sv */
`timescale 1ns/1ps

module simdLane #(
    parameter int LANE_ID = 0
) (
    input  logic clk,
    input  logic rst,
    laneCmdIf.lane cmd,
    laneReadIf.lane rd
);

    localparam logic [clusterPkg::DATA_WIDTH-1:0] LANE_VALUE = LANE_ID;

    logic [clusterPkg::DATA_WIDTH-1:0] regFile [1:clusterPkg::REG_COUNT-1];
    logic [clusterPkg::DATA_WIDTH-1:0] srcA;
    logic [clusterPkg::DATA_WIDTH-1:0] srcB;
    logic [clusterPkg::DATA_WIDTH-1:0] opB;
    logic [clusterPkg::DATA_WIDTH-1:0] unary;
    logic [clusterPkg::DATA_WIDTH-1:0] result;
    logic [clusterPkg::DATA_WIDTH-1:0] readData;
    logic                              predOk;
    logic                              writeEn;

    // r0 is the lane index, never stored
    function automatic logic [clusterPkg::DATA_WIDTH-1:0] regValue(
        input logic [clusterPkg::REG_IDX_W-1:0] idx
    );
        if (idx == '0) begin
            return LANE_VALUE;
        end
        return regFile[idx];
    endfunction

    always_comb begin
        srcA  = regValue(cmd.rs1);
        srcB  = regValue(cmd.rs2);
        opB   = cmd.useImm ? cmd.imm : srcB;
        unary = cmd.useImm ? cmd.imm : srcA;                // P-type load goes through ABS
    end

    always_comb begin
        case (cmd.aluOp)
            clusterPkg::ALU_SUB:  result = srcA - opB;
            clusterPkg::ALU_MUL:  result = srcA * opB;      // Low 32 bits
            clusterPkg::ALU_SLT:  result = {31'b0, $signed(srcA) < $signed(opB)};
            clusterPkg::ALU_SGT:  result = {31'b0, $signed(srcA) > $signed(opB)};
            clusterPkg::ALU_SEQ:  result = {31'b0, srcA == opB};
            clusterPkg::ALU_SNEZ: result = {31'b0, unary != '0};
            clusterPkg::ALU_MIN:  result = ($signed(srcA) < $signed(opB)) ? srcA : opB;
            clusterPkg::ALU_ABS:  result = unary[clusterPkg::DATA_WIDTH-1] ? -unary : unary;
            clusterPkg::ALU_SLLI: result = srcA << opB[4:0];
            default:              result = srcA + opB;
        endcase
    end

    assign predOk  = !cmd.predicated || regFile[clusterPkg::REG_COUNT-1][0];
    assign writeEn = cmd.valid && cmd.regWrite && predOk && (cmd.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < clusterPkg::REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeEn) begin
            regFile[cmd.rd] <= result;
        end
    end

    // Forward the write of this cycle so a read issued alongside sees it
    always_comb begin
        if (writeEn && (cmd.rd == rd.regIdx)) begin
            readData = result;
        end else begin
            readData = regValue(rd.regIdx);
        end
    end

    assign rd.data[LANE_ID] = readData;

    cmdInRange: assert property (@(posedge clk) disable iff (rst)
        cmd.valid |-> (cmd.rd < clusterPkg::REG_COUNT) && (cmd.rs1 < clusterPkg::REG_COUNT)
                      && (cmd.rs2 < clusterPkg::REG_COUNT)
                      && (cmd.aluOp != clusterPkg::ALU_DIV))
        else $error("simdLane %0d: malformed command from front end", LANE_ID);

endmodule

/* resultCollector.sv */
`timescale 1ns/1ps

module resultCollector #(
    parameter int NUM_LANES = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [clusterPkg::ADDR_WIDTH-1:0]   arAddr,
    input  logic                                arValid,
    output logic                                arReady,
    output logic [clusterPkg::DATA_WIDTH-1:0]   rData,
    output logic [1:0]                          rResp,
    output logic                                rValid,
    input  logic                                rReady,
    laneReadIf.collector                        rdPort,
    input  logic                                exited
);

    localparam int AW = clusterPkg::ADDR_WIDTH;
    localparam int LS = clusterPkg::LANE_SHIFT;

    logic [AW-1:0]                      offset;
    logic [AW-LS-1:0]                   laneSel;
    logic                               isStatus;
    logic                               isReg;
    logic                               accept;
    logic [clusterPkg::DATA_WIDTH-1:0]  laneData;

    assign arReady = !rValid;
    assign accept  = arValid && arReady;

    // Register window: lane in the upper bits, register in bits 5..2
    assign offset        = arAddr - clusterPkg::REG_BASE;
    assign laneSel       = offset[AW-1:LS];
    assign rdPort.regIdx = offset[LS-1:2];

    assign isStatus = (arAddr == clusterPkg::STATUS_ADDR);
    assign isReg    = (arAddr >= clusterPkg::REG_BASE) && (arAddr[1:0] == 2'b00)
                      && (laneSel < NUM_LANES);

    always_comb begin
        laneData = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (laneSel == i) begin
                laneData = rdPort.data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rValid <= 1'b0;
        end else if (accept) begin
            rValid <= 1'b1;
        end else if (rReady) begin
            rValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (isStatus) begin
                rData <= {{(clusterPkg::DATA_WIDTH-1){1'b0}}, exited};   // Bit 0 is exited
                rResp <= clusterPkg::RESP_OKAY;
            end else if (isReg) begin
                rData <= laneData;
                rResp <= clusterPkg::RESP_OKAY;
            end else begin
                rData <= '0;
                rResp <= clusterPkg::RESP_SLVERR;
            end
        end
    end

    rHold: assert property (@(posedge clk) disable iff (rst)
        rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
        else $error("resultCollector: read response changed before rReady");

endmodule

/* laneCluster.sv */
`timescale 1ns/1ps

module laneCluster #(
    parameter int NUM_LANES = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [clusterPkg::ADDR_WIDTH-1:0]   awAddr,
    input  logic                                awValid,
    output logic                                awReady,
    input  logic [clusterPkg::DATA_WIDTH-1:0]   wData,
    input  logic [3:0]                          wStrb,     // Full-word writes only
    input  logic                                wValid,
    output logic                                wReady,
    output logic [1:0]                          bResp,
    output logic                                bValid,
    input  logic                                bReady,
    input  logic [clusterPkg::ADDR_WIDTH-1:0]   arAddr,
    input  logic                                arValid,
    output logic                                arReady,
    output logic [clusterPkg::DATA_WIDTH-1:0]   rData,
    output logic [1:0]                          rResp,
    output logic                                rValid,
    input  logic                                rReady
);

    logic exited;

    laneCmdIf cmdBus ();
    laneReadIf #(.NUM_LANES(NUM_LANES)) readBus ();

    issueFrontend frontend (
        .clk     (clk),
        .rst     (rst),
        .awAddr  (awAddr),
        .awValid (awValid),
        .awReady (awReady),
        .wData   (wData),
        .wValid  (wValid),
        .wReady  (wReady),
        .bResp   (bResp),
        .bValid  (bValid),
        .bReady  (bReady),
        .cmd     (cmdBus.issue),
        .exited  (exited)
    );

    // Identical lanes, each knows only its index
    for (genvar i = 0; i < NUM_LANES; i++) begin : lanes
        simdLane #(.LANE_ID(i)) lane (
            .clk (clk),
            .rst (rst),
            .cmd (cmdBus.lane),
            .rd  (readBus.lane)
        );
    end

    resultCollector #(.NUM_LANES(NUM_LANES)) collector (
        .clk     (clk),
        .rst     (rst),
        .arAddr  (arAddr),
        .arValid (arValid),
        .arReady (arReady),
        .rData   (rData),
        .rResp   (rResp),
        .rValid  (rValid),
        .rReady  (rReady),
        .rdPort  (readBus.collector),
        .exited  (exited)
    );

endmodule

/* laneCluster_tb.sv */
`timescale 1ns/1ps

module laneCluster_tb;

    localparam int NUM_LANES = 4;
    localparam int RAND_OPS  = 27;                  // Three rounds of the nine R ops
    localparam int TXN_COUNT = RAND_OPS * (NUM_LANES + 1) + NUM_LANES * 16 + 80;

    logic        clk = 1'b0;
    logic        rst;
    logic [11:0] awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [11:0] arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;

    logic [31:0] model [NUM_LANES][16];             // r0 holds the lane index
    logic        modelExited;
    logic [1:0]  expBResp;
    logic [1:0]  expRResp;
    logic [31:0] expRData;
    int          mismatchCount = 0;
    int          protocolCount = 0;
    integer      seed = 32'hf7a9d97d;
    // ADD SUB MUL SLT SGT SEQ SNEZ MIN ABS
    logic [3:0]  rOps [9] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9};

    laneCluster #(.NUM_LANES(NUM_LANES)) DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] rWord(input logic [3:0] f4, input logic [3:0] rd, rs1, rs2);
        return {clusterPkg::Rtype, 1'b0, rd, rs1, rs2, 2'b00, f4, 10'd0};
    endfunction

    function automatic logic [31:0] iWord(input logic [3:0] f4, input logic [3:0] rd, rs1,
                                          input logic [9:0] imm);
        return {clusterPkg::Itype, 1'b0, rd, rs1, 6'd0, f4, imm};
    endfunction

    function automatic logic [31:0] pWord(input logic pred, input logic [3:0] rd,
                                          input logic [23:0] imm);
        return {clusterPkg::Ptype, pred, rd, imm};
    endfunction

    function automatic logic [31:0] cWord(input logic [2:0] f3);
        return {clusterPkg::Ctype, 1'b0, 12'd0, 2'b00, 1'b0, f3, 10'd0};
    endfunction

    function automatic logic [31:0] aluRef(input logic [3:0] op, input logic [31:0] a, b);
        case (op)
            4'd1:    return a - b;
            4'd2:    return a * b;
            4'd4:    return {31'd0, $signed(a) < $signed(b)};
            4'd5:    return {31'd0, $signed(a) > $signed(b)};
            4'd6:    return {31'd0, a == b};
            4'd7:    return {31'd0, a != 32'd0};       // Unary on rs1
            4'd8:    return ($signed(a) < $signed(b)) ? a : b;
            4'd9:    return a[31] ? -a : a;
            4'd10:   return a << b[4:0];
            default: return a + b;
        endcase
    endfunction

    // Reference update for one write, sets the expected write response
    task automatic applyWrite(input logic [11:0] addr, input logic [31:0] w);
        logic [2:0]  op;
        logic [3:0]  f4;
        logic [31:0] value;
        logic        legal;
        op    = w[31:29];
        f4    = w[13:10];
        legal = (op == clusterPkg::Rtype) || (op == clusterPkg::Itype)
                || (op == clusterPkg::Ptype) || (op == clusterPkg::Ctype && f4[2:0] >= 3'd6);
        expBResp = clusterPkg::RESP_SLVERR;
        if (addr != clusterPkg::INSTR_ADDR || modelExited || !legal) begin
            return;
        end
        expBResp = clusterPkg::RESP_OKAY;
        if (op == clusterPkg::Ctype) begin
            modelExited = modelExited || (f4[2:0] == 3'd7);
            return;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (w[28] && !model[l][15][0]) continue;  // Predicate off in this lane
            if (op == clusterPkg::Ptype) begin
                value = {8'd0, w[23:0]};
            end else if (op == clusterPkg::Itype) begin
                value = aluRef((f4 == 4'd2 || f4 == 4'd10) ? f4 : 4'd0, model[l][w[23:20]],
                               {{22{w[9]}}, w[9:0]});
            end else begin
                value = aluRef((f4 == 4'd3 || f4 > 4'd9) ? 4'd0 : f4, model[l][w[23:20]],
                               model[l][w[19:16]]);
            end
            if (w[27:24] != 4'd0) model[l][w[27:24]] = value;
        end
    endtask

    task automatic expectRead(input logic [11:0] addr);
        logic [11:0] offset;
        offset   = addr - clusterPkg::REG_BASE;
        expRData = '0;
        expRResp = clusterPkg::RESP_SLVERR;
        if (addr == clusterPkg::STATUS_ADDR) begin
            expRData = {31'd0, modelExited};
            expRResp = clusterPkg::RESP_OKAY;
        end else if (addr >= clusterPkg::REG_BASE && addr[1:0] == 2'b00
                     && int'(offset[11:6]) < NUM_LANES) begin
            expRData = model[offset[11:6]][offset[5:2]];
            expRResp = clusterPkg::RESP_OKAY;
        end
    endtask

    task automatic writeWord(input logic [11:0] addr, input logic [31:0] w);
        int hold;
        hold = $unsigned($random(seed)) % 4;      // Cycles of bReady back-pressure
        @(posedge clk);
        applyWrite(addr, w);
        awAddr  <= addr;
        wData   <= w;
        awValid <= 1'b1;
        wValid  <= 1'b1;
        do @(posedge clk); while (!(awReady && wReady));
        awValid <= 1'b0;
        wValid  <= 1'b0;
        repeat (hold) @(posedge clk);
        bReady <= 1'b1;
        do @(posedge clk); while (!bValid);
        bReady <= 1'b0;
    endtask

    task automatic readWord(input logic [11:0] addr);
        int hold;
        hold = $unsigned($random(seed)) % 4;
        @(posedge clk);
        expectRead(addr);
        arAddr  <= addr;
        arValid <= 1'b1;
        do @(posedge clk); while (!arReady);
        arValid <= 1'b0;
        repeat (hold) @(posedge clk);
        rReady <= 1'b1;
        do @(posedge clk); while (!rValid);
        rReady <= 1'b0;
    endtask

    task automatic issue(input logic [31:0] w);
        writeWord(clusterPkg::INSTR_ADDR, w);
    endtask

    task automatic readLanes(input logic [3:0] r);
        for (int l = 0; l < NUM_LANES; l++) begin
            readWord(clusterPkg::REG_BASE + 12'(l * 64 + int'(r) * 4));
        end
    endtask

    bRespCheck: assert property (@(posedge clk) disable iff (rst)
        bValid && bReady |-> bResp == expBResp)
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: bResp got %0d expected %0d", $time, bResp, expBResp);
        end

    rRespCheck: assert property (@(posedge clk) disable iff (rst)
        rValid && rReady |-> rResp == expRResp)
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: rResp got %0d expected %0d", $time, rResp, expRResp);
        end

    rDataCheck: assert property (@(posedge clk) disable iff (rst)
        rValid && rReady |-> rData == expRData)
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: rData got %h expected %h", $time, rData, expRData);
        end

    // Write pair taken together, only while no response is pending
    awReadyCheck: assert property (@(posedge clk) disable iff (rst)
        awReady == (awValid && wValid && !bValid))
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: awReady got %0b expected %0b", $time, $sampled(awReady),
                     $sampled(awValid) && $sampled(wValid) && !$sampled(bValid));
        end

    wReadyCheck: assert property (@(posedge clk) disable iff (rst)
        wReady == (awValid && wValid && !bValid))
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: wReady got %0b expected %0b", $time, $sampled(wReady),
                     $sampled(awValid) && $sampled(wValid) && !$sampled(bValid));
        end

    arReadyCheck: assert property (@(posedge clk) disable iff (rst)
        arReady == !rValid)
        else begin
            mismatchCount++;
            $display("Mismatch at %0t: arReady got %0b expected %0b", $time, $sampled(arReady),
                     !$sampled(rValid));
        end

    bHeld: assert property (@(posedge clk) disable iff (rst)
        bValid && !bReady |=> bValid && $stable(bResp))
        else begin
            protocolCount++;
            $display("At %0t the write response dropped or changed while bReady was low", $time);
        end

    rHeld: assert property (@(posedge clk) disable iff (rst)
        rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
        else begin
            protocolCount++;
            $display("At %0t the read response dropped or changed while rReady was low", $time);
        end

    resetQuiet: assert property (@(posedge clk) rst |=> !bValid && !rValid)
        else begin
            protocolCount++;
            $display("At %0t bValid or rValid was high during or right after reset", $time);
        end

    initial begin
        repeat (TXN_COUNT * 50) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", TXN_COUNT * 50);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [3:0] dst;
        logic [3:0] srcA;
        logic [3:0] srcB;
        rst     <= 1'b1;
        awAddr  <= '0;
        awValid <= 1'b0;
        wData   <= '0;
        wStrb   <= 4'hF;
        wValid  <= 1'b0;
        bReady  <= 1'b0;
        arAddr  <= '0;
        arValid <= 1'b0;
        rReady  <= 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int r = 0; r < 16; r++) model[l][r] = (r == 0) ? 32'(l) : 32'd0;
        end
        modelExited = 1'b0;
        expBResp    = '0;
        expRResp    = '0;
        expRData    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        readWord(clusterPkg::STATUS_ADDR);
        readLanes(4'd0);

        // Loaded constants mixed with r0 give lane-dependent operands
        issue(pWord(1'b0, 4'd1, 24'($random(seed))));
        issue(pWord(1'b0, 4'd2, 24'h800123));
        issue(rWord(4'd1, 4'd3, 4'd0, 4'd1));       // r3 = lane - r1
        for (int i = 0; i < RAND_OPS; i++) begin
            dst  = 4'(1 + $unsigned($random(seed)) % 14);
            srcA = 4'($unsigned($random(seed)) % 8);
            srcB = 4'($unsigned($random(seed)) % 8);
            issue(rWord(rOps[i % 9], dst, srcA, srcB));
            readLanes(dst);
        end

        issue(iWord(4'd0, 4'd5, 4'd0, 10'h3FD));    // lane - 3
        issue(iWord(4'd2, 4'd6, 4'd3, 10'h3F9));    // r3 * -7
        issue(iWord(4'd10, 4'd7, 4'd0, 10'h3E5));   // Shift by 5
        issue(iWord(4'd12, 4'd8, 4'd5, 10'h200));   // Unlisted funct4 acts as ADD
        issue(iWord(4'd0, 4'd0, 4'd1, 10'd9));
        for (int r = 5; r <= 8; r++) readLanes(4'(r));
        readLanes(4'd0);

        // Predicate true in lane 2 only
        issue(pWord(1'b0, 4'd9, 24'd2));
        issue(pWord(1'b0, 4'd10, 24'h55));
        issue(rWord(4'd6, 4'd15, 4'd0, 4'd9));
        issue(pWord(1'b1, 4'd10, 24'hABCDE));
        readLanes(4'd15);
        readLanes(4'd10);

        issue({clusterPkg::Mtype, 1'b0, 4'd10, 24'h000001});
        issue({clusterPkg::Ftype, 1'b0, 4'd10, 24'h000002});
        issue(cWord(3'd2));                         // Unlisted C-type funct3
        writeWord(12'h008, pWord(1'b0, 4'd10, 24'h777));
        readWord(clusterPkg::REG_BASE + 12'(NUM_LANES * 64));
        readWord(12'h00C);
        issue(cWord(3'd6));                         // SYNC
        readLanes(4'd10);
        readWord(clusterPkg::STATUS_ADDR);

        issue(cWord(3'd7));
        readWord(clusterPkg::STATUS_ADDR);
        issue(pWord(1'b0, 4'd10, 24'h4242));
        issue(rWord(4'd0, 4'd11, 4'd0, 4'd0));
        issue(cWord(3'd6));
        readWord(clusterPkg::STATUS_ADDR);
        for (int r = 0; r < 16; r++) readLanes(4'(r));

        repeat (3) @(posedge clk);
        $display("Errors: %0d mismatches, %0d protocol failures", mismatchCount, protocolCount);
        if (mismatchCount + protocolCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
clusterPkg.sv
laneCmdIf.sv
laneReadIf.sv
controlUnit.sv
issueFrontend.sv
simdLane.sv
resultCollector.sv
laneCluster.sv
laneCluster_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= laneCluster_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
